// ==== tb.f ====
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/pipe_if.sv
hw/regfile.sv
hw/hazard_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/pipe_core.sv
verification/tb_pipe_core.sv

// ==== verification/tb_pipe_core.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_pipe_core import isa_pkg::*; ();

    localparam int IMEM_WORDS = 256;  // indexed by imem_addr[9:2]
    localparam int PC_TIMEOUT = 400;  // cycles allowed to fetch past the program end
    localparam int DRAIN      = 6;    // retire at n+3, plus one load-use stall and margin

    typedef enum int {K_ADD, K_SUB, K_ADDI, K_LW, K_SW, K_BEQ} op_kind_e;

    logic               clk;
    logic               rst;
    logic [`XLEN-1:0]   imem_addr;
    logic [31:0]        imem_data;
    logic               retire_valid;
    logic [`REG_AW-1:0] retire_rd;
    logic [`XLEN-1:0]   retire_data;

    logic [31:0]        imem [IMEM_WORDS];
    op_kind_e           prog_op [$];      // program as written, for the model
    int                 prog_rd [$];
    int                 prog_rs1 [$];
    int                 prog_rs2 [$];
    logic [`XLEN-1:0]   prog_imm [$];     // sign extended, bytes for beq

    logic [`XLEN-1:0]   model_mem [`DMEM_WORDS]; // dmem has no reset, so this persists too
    bit                 mem_known [16];   // random lw only reads words already stored

    logic [`REG_AW-1:0] exp_rd [$];
    logic [`XLEN-1:0]   exp_data [$];
    logic [`REG_AW-1:0] ret_rd [$];
    logic [`XLEN-1:0]   ret_data [$];
    time                ret_time [$];
    int                 errors;
    int                 tests;

    pipe_core pipe_core_inst (
        .clk          (clk),
        .rst          (rst),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    // instruction memory, answers the pc 1 ns after the edge
    always @(posedge clk) begin
        #1;
        imem_data = imem[imem_addr[9:2]];
    end

    // retire stream, sampled mid cycle where it is settled
    always @(negedge clk) begin
        if (!rst && retire_valid === 1'b1) begin
            ret_rd.push_back(retire_rd);
            ret_data.push_back(retire_data);
            ret_time.push_back($time);
        end
    end

    function automatic logic [`XLEN-1:0] sext12(input logic [11:0] v);
        return {{(`XLEN-12){v[11]}}, v};
    endfunction

    // build one instruction word through the format views
    function automatic instr_u encode(input op_kind_e op, input int rd, input int rs1,
                                      input int rs2, input logic [`XLEN-1:0] imm);
        instr_u w;
        w = '0;
        case (op)
            K_ADD, K_SUB: begin
                w.r_fmt.opcode = OP_REG;
                w.r_fmt.funct3 = F3_ADD;
                w.r_fmt.funct7 = (op == K_SUB) ? F7_SUB : F7_ADD;
                w.r_fmt.rd     = rd[4:0];
                w.r_fmt.rs1    = rs1[4:0];
                w.r_fmt.rs2    = rs2[4:0];
            end
            K_ADDI, K_LW: begin
                w.i_fmt.opcode = (op == K_LW) ? OP_LOAD : OP_IMM;
                w.i_fmt.funct3 = (op == K_LW) ? F3_WORD : F3_ADD;
                w.i_fmt.rd     = rd[4:0];
                w.i_fmt.rs1    = rs1[4:0];
                w.i_fmt.imm    = imm[11:0];
            end
            K_SW: begin
                w.s_fmt.opcode = OP_STORE;
                w.s_fmt.funct3 = F3_WORD;
                w.s_fmt.rs1    = rs1[4:0];
                w.s_fmt.rs2    = rs2[4:0];
                w.s_fmt.imm_hi = imm[11:5];
                w.s_fmt.imm_lo = imm[4:0];
            end
            K_BEQ: begin
                w.b_fmt.opcode   = OP_BRANCH;
                w.b_fmt.funct3   = F3_BEQ;
                w.b_fmt.rs1      = rs1[4:0];
                w.b_fmt.rs2      = rs2[4:0];
                w.b_fmt.imm_12   = imm[12];
                w.b_fmt.imm_11   = imm[11];
                w.b_fmt.imm_10_5 = imm[10:5];
                w.b_fmt.imm_4_1  = imm[4:1];
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic clear_program();
        prog_op.delete();
        prog_rd.delete();
        prog_rs1.delete();
        prog_rs2.delete();
        prog_imm.delete();
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = {i[24:0], 7'h7f}; // opcode outside the subset, fetched as a bubble
    endtask

    task automatic add_instr(input op_kind_e op, input int rd, input int rs1, input int rs2,
                             input logic [`XLEN-1:0] imm);
        imem[prog_op.size()] = encode(op, rd, rs1, rs2, imm);
        prog_op.push_back(op);
        prog_rd.push_back(rd);
        prog_rs1.push_back(rs1);
        prog_rs2.push_back(rs2);
        prog_imm.push_back(imm);
    endtask

    // sequential reference, one instruction at a time
    task automatic run_model();
        logic [`XLEN-1:0] r [32];
        logic [`XLEN-1:0] v;
        logic [`XLEN-1:0] addr;
        int               pc;
        int               steps;
        int               rd;
        bit               wr;
        bit               taken;
        for (int i = 0; i < 32; i++)
            r[i] = '0;
        pc = 0;
        steps = 0;
        exp_rd.delete();
        exp_data.delete();
        while (pc < prog_op.size() && steps < 1000) begin
            wr    = 1'b1;
            taken = 1'b0;
            v     = '0;
            rd    = prog_rd[pc];
            addr  = r[prog_rs1[pc]] + prog_imm[pc];
            case (prog_op[pc])
                K_ADD:  v = r[prog_rs1[pc]] + r[prog_rs2[pc]];
                K_SUB:  v = r[prog_rs1[pc]] - r[prog_rs2[pc]];
                K_ADDI: v = addr;
                K_LW:   v = model_mem[addr[31:2]];
                K_SW: begin
                    model_mem[addr[31:2]] = r[prog_rs2[pc]];
                    wr = 1'b0;
                end
                default: begin // beq
                    taken = (r[prog_rs1[pc]] == r[prog_rs2[pc]]);
                    wr    = 1'b0;
                end
            endcase
            if (wr) begin
                if (rd != 0)
                    r[rd] = v;
                exp_rd.push_back(rd[`REG_AW-1:0]);
                exp_data.push_back((rd == 0) ? '0 : v); // x0 always retires zero
            end
            pc = taken ? pc + ($signed(prog_imm[pc]) >>> 2) : pc + 1;
            steps++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        ret_rd.delete();
        ret_data.delete();
        ret_time.delete();
    endtask

    task automatic wait_for_pc(input logic [`XLEN-1:0] addr, output bit reached);
        int n;
        n = 0;
        while (imem_addr < addr && n < PC_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        reached = (imem_addr >= addr);
    endtask

    task automatic check_reg(input int idx, input logic [`REG_AW-1:0] exp_r, act_r,
                             input logic [`XLEN-1:0] exp_d, act_d, input time at);
        if (act_r !== exp_r) begin
            $display("MISMATCH t=%0t retire_rd[%0d] expected %0d actual %0d",
                     at, idx, exp_r, act_r);
            errors++;
        end
        if (act_d !== exp_d) begin
            $display("MISMATCH t=%0t retire_data[%0d] expected %h actual %h",
                     at, idx, exp_d, act_d);
            errors++;
        end
    endtask

    task automatic check_count(input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            $display("MISMATCH t=%0t retire_count expected %0d actual %0d", $time, exp_n, act_n);
            errors++;
        end
    endtask

    // reset, run to the end of the program, drain, compare against the model
    task automatic run_program(input string name);
        int err0;
        int n;
        bit reached;
        err0 = errors;
        run_model();
        apply_reset();
        wait_for_pc(prog_op.size() * 4, reached);
        if (!reached) begin
            $display("%s: timeout, fetch never got past the end of the program", name);
            errors++;
        end else begin
            repeat (DRAIN) @(posedge clk);
            #1;
            check_count(exp_rd.size(), ret_rd.size());
            n = (exp_rd.size() < ret_rd.size()) ? exp_rd.size() : ret_rd.size();
            for (int i = 0; i < n; i++)
                check_reg(i, exp_rd[i], ret_rd[i], exp_data[i], ret_data[i], ret_time[i]);
        end
        tests++;
        $display("test %-12s %0d instructions, %0d retired, %0d errors",
                 name, prog_op.size(), ret_rd.size(), errors - err0);
    endtask

    task automatic test_fwd_chain();
        clear_program();
        add_instr(K_ADDI, 1, 0, 0, 5);
        add_instr(K_ADDI, 2, 0, 0, 7);
        add_instr(K_ADD,  3, 1, 2, 0);   // x2 from mem, x1 from wb
        add_instr(K_SUB,  4, 3, 1, 0);
        add_instr(K_ADD,  5, 4, 3, 0);   // both forwarded
        add_instr(K_ADDI, 5, 5, 0, -3);
        add_instr(K_SUB,  6, 5, 5, 0);
        run_program("fwd_chain");
    endtask

    task automatic test_x0();
        clear_program();
        add_instr(K_ADDI, 0, 0, 0, 9);   // dropped write
        add_instr(K_ADD,  1, 0, 0, 0);   // x0 right behind, must not forward 9
        add_instr(K_ADDI, 0, 1, 0, 5);
        add_instr(K_ADDI, 2, 0, 0, 4);
        add_instr(K_SUB,  3, 2, 0, 0);
        run_program("x0");
    endtask

    task automatic test_load_use();
        clear_program();
        add_instr(K_ADDI, 1, 0, 0, 100);
        add_instr(K_SW,   0, 0, 1, 8);
        add_instr(K_ADDI, 2, 0, 0, 23);
        add_instr(K_LW,   3, 0, 0, 8);
        add_instr(K_ADD,  4, 3, 2, 0);   // load use, one stall
        add_instr(K_ADDI, 5, 4, 0, 1);
        run_program("load_use");
    endtask

    task automatic test_store_fwd();
        clear_program();
        add_instr(K_ADDI, 1, 0, 0, 77);
        add_instr(K_SW,   0, 0, 1, 16);
        add_instr(K_LW,   2, 0, 0, 16);
        add_instr(K_SW,   0, 0, 2, 20);  // store data straight from the load
        add_instr(K_LW,   3, 0, 0, 20);
        add_instr(K_ADD,  4, 3, 0, 0);
        run_program("store_fwd");
    endtask

    task automatic test_branch();
        clear_program();
        add_instr(K_ADDI, 1, 0, 0, 3);
        add_instr(K_ADDI, 2, 0, 0, 3);
        add_instr(K_BEQ,  0, 1, 2, 12);  // taken, skips the next two
        add_instr(K_ADDI, 3, 0, 0, 1);
        add_instr(K_ADDI, 4, 0, 0, 2);
        add_instr(K_ADDI, 5, 0, 0, 5);
        add_instr(K_BEQ,  0, 1, 0, 8);   // not taken
        add_instr(K_ADDI, 6, 0, 0, 6);
        add_instr(K_ADDI, 7, 0, 0, 7);
        run_program("branch");
    endtask

    task automatic test_random();
        int k;
        int a;
        int b;
        int c;
        int off;
        for (int s = 0; s < 20; s++) begin
            clear_program();
            for (int r = 1; r <= 4; r++)
                add_instr(K_ADDI, r, 0, 0, sext12(12'($urandom_range(0, 4095))));
            for (int i = 0; i < 16; i++) begin
                k   = $urandom_range(0, 4);
                a   = $urandom_range(0, 4); // x0 included on purpose
                b   = $urandom_range(0, 4);
                c   = $urandom_range(0, 4);
                off = $urandom_range(0, 15);
                case (k)
                    0: add_instr(K_ADD, a, b, c, 0);
                    1: add_instr(K_SUB, a, b, c, 0);
                    2: add_instr(K_ADDI, a, b, 0, sext12(12'($urandom_range(0, 4095))));
                    3: begin
                        if (mem_known[off]) begin
                            add_instr(K_LW, a, 0, 0, off * 4);
                        end else begin
                            add_instr(K_SW, 0, 0, c, off * 4);
                            mem_known[off] = 1'b1;
                        end
                    end
                    default: begin
                        add_instr(K_SW, 0, 0, c, off * 4);
                        mem_known[off] = 1'b1;
                    end
                endcase
            end
            run_program($sformatf("random_%0d", s));
        end
    endtask

    initial begin
        rst       = 1'b1;
        imem_data = '0;
        errors    = 0;
        tests     = 0;
        void'($urandom(32'hdcc0ee90));
        clear_program();
        test_fwd_chain();
        test_x0();
        test_load_use();
        test_store_fwd();
        test_branch();
        test_random();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== hw/pipe_core.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module pipe_core import pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    output logic [`XLEN-1:0]   imem_addr,
    input  logic [31:0]        imem_data,
    output logic               retire_valid,
    output logic [`REG_AW-1:0] retire_rd,
    output logic [`XLEN-1:0]   retire_data
);

    logic               stall, flush, fwd_ls;
    fwd_sel_e           fwd_rs1, fwd_rs2;
    logic               branch_taken;
    logic [`XLEN-1:0]   branch_target;
    logic               wb_we;
    logic [`REG_AW-1:0] wb_rd;
    logic [`XLEN-1:0]   wb_data;

    pipe_if de_if (); // id/ex
    pipe_if em_if (); // ex/mem

    decode_stage decode_stage_inst (
        .clk (clk), .rst (rst), .imem_addr (imem_addr), .imem_data (imem_data),
        .stall (stall), .flush (flush),
        .branch_taken (branch_taken), .branch_target (branch_target),
        .de (de_if.src), .wb_we (wb_we), .wb_rd (wb_rd), .wb_data (wb_data)
    );

    execute_stage execute_stage_inst (
        .clk (clk), .rst (rst), .de (de_if.dst), .em (em_if.src),
        .fwd_rs1 (fwd_rs1), .fwd_rs2 (fwd_rs2), .wb_data (wb_data), .stall (stall),
        .branch_taken (branch_taken), .branch_target (branch_target)
    );

    memory_stage memory_stage_inst (
        .clk (clk), .rst (rst), .em (em_if.dst), .fwd_ls (fwd_ls),
        .wb_we (wb_we), .wb_rd (wb_rd), .wb_data (wb_data)
    );

    hazard_unit hazard_unit_inst (
        .rd_m (em_if.rd), .rd_w (wb_rd), .rs1_e (de_if.rs1), .rs2_e (de_if.rs2),
        .rs1_used_e (de_if.ctrl.use_rs1), .rs2_used_e (de_if.ctrl.use_rs2),
        .reg_write_m (em_if.ctrl.reg_write), .reg_write_w (wb_we),
        .load_m (em_if.ctrl.load), .store_e (de_if.ctrl.store),
        .branch_taken (branch_taken), .stall (stall), .flush (flush),
        .fwd_rs1 (fwd_rs1), .fwd_rs2 (fwd_rs2), .fwd_ls (fwd_ls)
    );

    // retirement is the write-back port
    assign retire_valid = wb_we;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module memory_stage (
    input  logic               clk,
    input  logic               rst,
    pipe_if.dst                em,
    input  logic               fwd_ls,
    output logic               wb_we,
    output logic [`REG_AW-1:0] wb_rd,
    output logic [`XLEN-1:0]   wb_data
);

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]   dmem [`DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic [`XLEN-1:0]   st_data;
    logic               fwd_ls_q;  // load ahead of this store is now in wb
    logic [`XLEN-1:0]   rdata_q;   // sync read, lands alongside mem/wb
    logic [`XLEN-1:0]   result_q;
    logic [`REG_AW-1:0] rd_q;
    logic               we_q, load_q;

    assign word_idx = em.alu_result[DMEM_AW+1:2]; // word addressed, low bits ignored
    assign st_data  = fwd_ls_q ? wb_data : em.store_data;

    always_ff @(posedge clk) begin
        if (rst)
            fwd_ls_q <= 1'b0;
        else
            fwd_ls_q <= fwd_ls;
    end

    always_ff @(posedge clk) begin
        if (em.ctrl.valid && em.ctrl.store)
            dmem[word_idx] <= st_data;
        rdata_q <= dmem[word_idx];
    end

    // mem/wb register
    always_ff @(posedge clk) begin
        if (rst) begin
            we_q   <= 1'b0;
            load_q <= 1'b0;
        end else begin
            we_q   <= em.ctrl.valid && em.ctrl.reg_write;
            load_q <= em.ctrl.valid && em.ctrl.load;
        end
    end

    always_ff @(posedge clk) begin
        rd_q     <= em.rd;
        result_q <= em.alu_result;
    end

    assign wb_we = we_q;
    assign wb_rd = rd_q;

    always_comb begin
        if (rd_q == '0)
            wb_data = '0; // x0 result is always zero
        else if (load_q)
            wb_data = rdata_q;
        else
            wb_data = result_q;
    end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module execute_stage import pipe_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    pipe_if.dst              de,
    pipe_if.src              em,
    input  fwd_sel_e         fwd_rs1,
    input  fwd_sel_e         fwd_rs2,
    input  logic [`XLEN-1:0] wb_data,
    input  logic             stall,
    output logic             branch_taken,
    output logic [`XLEN-1:0] branch_target
);

    logic [`XLEN-1:0] op_a, op_b;     // operands after forwarding
    logic [`XLEN-1:0] alu_b, alu_out;
    logic [`XLEN-1:0] hold_a, hold_b; // operands caught during a load-use stall
    logic             held;           // last cycle was a stall

    // a producer that was in wb during the stall has left by now,
    // so the held copy stands in for the stale id/ex value
    function automatic logic [`XLEN-1:0] pick_operand(
        input fwd_sel_e         sel,
        input logic [`XLEN-1:0] id_val,
        input logic [`XLEN-1:0] hold_val
    );
        case (sel)
            FWD_MEM: return em.alu_result;
            FWD_WB:  return wb_data;
            default: return held ? hold_val : id_val;
        endcase
    endfunction

    always_comb begin
        op_a    = pick_operand(fwd_rs1, de.op_a, hold_a);
        op_b    = pick_operand(fwd_rs2, de.op_b, hold_b);
        alu_b   = de.ctrl.use_imm ? de.imm : op_b;
        alu_out = de.ctrl.alu_sub ? (op_a - alu_b) : (op_a + alu_b); // add, sub or address

        // operands are not final while stalled
        branch_taken  = de.ctrl.valid && de.ctrl.branch && (op_a == op_b) && !stall;
        branch_target = de.pc + de.imm;
    end

    always_ff @(posedge clk) begin
        if (rst)
            held <= 1'b0;
        else
            held <= stall;
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            hold_a <= op_a;
            hold_b <= op_b;
        end
    end

    // ex/mem register, bubble inserted behind a stalled instruction
    always_ff @(posedge clk) begin
        if (rst || stall)
            em.ctrl <= '0;
        else
            em.ctrl <= de.ctrl;
    end

    always_ff @(posedge clk) begin
        em.rd         <= de.rd;
        em.alu_result <= alu_out;
        em.store_data <= op_b; // sw data is rs2
    end

    // fields this boundary does not carry
    assign em.pc   = '0;
    assign em.rs1  = '0;
    assign em.rs2  = '0;
    assign em.op_a = '0;
    assign em.op_b = '0;
    assign em.imm  = '0;

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    output logic [`XLEN-1:0]   imem_addr,
    input  logic [31:0]        imem_data,
    input  logic               stall,
    input  logic               flush,
    input  logic               branch_taken,
    input  logic [`XLEN-1:0]   branch_target,
    pipe_if.src                de,
    input  logic               wb_we,
    input  logic [`REG_AW-1:0] wb_rd,
    input  logic [`XLEN-1:0]   wb_data
);

    logic [`XLEN-1:0]   pc_q;
    instr_u             instr;
    ctrl_t              ctrl_d;
    logic [`XLEN-1:0]   imm_d;
    logic [`REG_AW-1:0] rd_d;
    logic [`XLEN-1:0]   rd1, rd2;
    logic is_reg, is_imm, is_load, is_store, is_branch;

    assign imem_addr = pc_q;
    assign instr     = imem_data; // answered combinationally by imem

    always_ff @(posedge clk) begin
        if (rst)
            pc_q <= `RESET_PC;
        else if (branch_taken)
            pc_q <= branch_target; // redirect from ex
        else if (!stall)
            pc_q <= pc_q + `XLEN'd4;
    end

    regfile regfile_inst (
        .clk (clk),
        .rst (rst),
        .rs1 (instr.r_fmt.rs1),
        .rs2 (instr.r_fmt.rs2),
        .rd1 (rd1),
        .rd2 (rd2),
        .we  (wb_we),
        .wa  (wb_rd),
        .wd  (wb_data)
    );

    always_comb begin
        // recognise the subset, anything else becomes a bubble
        is_reg    = (instr.r_fmt.opcode == OP_REG) && (instr.r_fmt.funct3 == F3_ADD) &&
                    ((instr.r_fmt.funct7 == F7_ADD) || (instr.r_fmt.funct7 == F7_SUB));
        is_imm    = (instr.i_fmt.opcode == OP_IMM)    && (instr.i_fmt.funct3 == F3_ADD);
        is_load   = (instr.i_fmt.opcode == OP_LOAD)   && (instr.i_fmt.funct3 == F3_WORD);
        is_store  = (instr.s_fmt.opcode == OP_STORE)  && (instr.s_fmt.funct3 == F3_WORD);
        is_branch = (instr.b_fmt.opcode == OP_BRANCH) && (instr.b_fmt.funct3 == F3_BEQ);

        ctrl_d.valid     = is_reg | is_imm | is_load | is_store | is_branch;
        ctrl_d.reg_write = is_reg | is_imm | is_load;
        ctrl_d.load      = is_load;
        ctrl_d.store     = is_store;
        ctrl_d.branch    = is_branch;
        ctrl_d.use_rs1   = ctrl_d.valid;                   // every op in the subset reads rs1
        ctrl_d.use_rs2   = is_reg | is_store | is_branch;
        ctrl_d.alu_sub   = is_reg && (instr.r_fmt.funct7 == F7_SUB);
        ctrl_d.use_imm   = is_imm | is_load | is_store;

        // immediate, taken through the view matching the opcode
        if (is_imm || is_load)
            imm_d = {{(`XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        else if (is_store)
            imm_d = {{(`XLEN-12){instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
        else if (is_branch)
            imm_d = {{(`XLEN-13){instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                     instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
        else
            imm_d = '0;

        // for sw/beq those bits are immediate, not a destination
        rd_d = ctrl_d.reg_write ? instr.r_fmt.rd : '0;
    end

    always_ff @(posedge clk) begin
        if (rst || flush)
            de.ctrl <= '0; // bubble
        else if (!stall)
            de.ctrl <= ctrl_d;
    end

    // id/ex payload, held while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            de.pc   <= pc_q;
            de.rs1  <= instr.r_fmt.rs1;
            de.rs2  <= instr.r_fmt.rs2;
            de.rd   <= rd_d;
            de.op_a <= rd1;
            de.op_b <= rd2;
            de.imm  <= imm_d;
        end
    end

    assign de.alu_result = '0; // produced in ex
    assign de.store_data = '0;

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module hazard_unit import pipe_pkg::*; (
    input  logic [`REG_AW-1:0] rd_m,
    input  logic [`REG_AW-1:0] rd_w,
    input  logic [`REG_AW-1:0] rs1_e,
    input  logic [`REG_AW-1:0] rs2_e,
    input  logic               rs1_used_e,  // ex instruction really reads rs1
    input  logic               rs2_used_e,  // ex instruction really reads rs2
    input  logic               reg_write_m,
    input  logic               reg_write_w,
    input  logic               load_m,      // load sitting in mem
    input  logic               store_e,     // store sitting in ex
    input  logic               branch_taken,
    output logic               stall,
    output logic               flush,
    output fwd_sel_e           fwd_rs1,
    output fwd_sel_e           fwd_rs2,
    output logic               fwd_ls       // registered in mem, patches store data one cycle on
);

    logic hit_m_rs1, hit_m_rs2; // mem stage writes the register ex wants
    logic hit_w_rs1, hit_w_rs2;

    always_comb begin
        hit_m_rs1 = reg_write_m && (rd_m != '0) && (rd_m == rs1_e);
        hit_m_rs2 = reg_write_m && (rd_m != '0) && (rd_m == rs2_e);
        hit_w_rs1 = reg_write_w && (rd_w != '0) && (rd_w == rs1_e);
        hit_w_rs2 = reg_write_w && (rd_w != '0) && (rd_w == rs2_e);

        fwd_rs1 = FWD_NONE;
        fwd_rs2 = FWD_NONE;
        if (rs1_used_e) begin
            if (hit_m_rs1)
                fwd_rs1 = FWD_MEM; // younger producer first
            else if (hit_w_rs1)
                fwd_rs1 = FWD_WB;
        end
        if (rs2_used_e) begin
            if (hit_m_rs2)
                fwd_rs2 = FWD_MEM;
            else if (hit_w_rs2)
                fwd_rs2 = FWD_WB;
        end

        // store data waiting on a load in mem can be taken from wb next cycle
        fwd_ls = store_e && load_m && hit_m_rs2;

        // sync dmem, load data only exists from wb on
        // store data on rs2 is exempt, covered by fwd_ls
        stall = load_m && ((rs1_used_e && (rd_m == rs1_e)) ||
                           (rs2_used_e && !store_e && (rd_m == rs2_e)));

        flush = branch_taken; // kill the instruction being fetched
    end

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    output logic [`XLEN-1:0]   rd1,
    output logic [`XLEN-1:0]   rd2,
    input  logic               we,
    input  logic [`REG_AW-1:0] wa,
    input  logic [`XLEN-1:0]   wd
);

    logic [`XLEN-1:0] regs [1:31]; // x0 has no storage

    // x0 reads zero, a same-cycle write is passed straight through
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] idx);
        if (idx == '0)
            return '0;
        else if (we && (wa == idx))
            return wd;
        else
            return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && (wa != '0)) begin // writes to x0 dropped
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd1 = read_port(rs1);
        rd2 = read_port(rs2);
    end

endmodule

// ==== hw/pipe_if.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

// one pipeline register boundary, written by the older stage and read by the younger
interface pipe_if import pipe_pkg::*; ();

    ctrl_t                ctrl;
    logic [`XLEN-1:0]     pc;
    logic [`REG_AW-1:0]   rs1;        // source indices, for the hazard unit
    logic [`REG_AW-1:0]   rs2;
    logic [`REG_AW-1:0]   rd;
    logic [`XLEN-1:0]     op_a;       // register values as read in decode
    logic [`XLEN-1:0]     op_b;
    logic [`XLEN-1:0]     imm;        // sign extended
    logic [`XLEN-1:0]     alu_result; // sum, difference or address
    logic [`XLEN-1:0]     store_data;

    modport src (output ctrl, pc, rs1, rs2, rd, op_a, op_b, imm, alu_result, store_data);
    modport dst (input  ctrl, pc, rs1, rs2, rd, op_a, op_b, imm, alu_result, store_data);

endinterface

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

    // operand source chosen by the hazard unit, newest data wins
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00, // value read in decode
        FWD_WB   = 2'b01, // mem/wb result
        FWD_MEM  = 2'b10  // ex/mem alu result
    } fwd_sel_e;

    // control bundle that rides along with each instruction
    // an all-zero bundle is a bubble
    typedef struct packed {
        logic valid;     // stage holds a real instruction
        logic reg_write; // writes rd at write-back
        logic load;
        logic store;
        logic branch;    // beq, resolved in ex
        logic use_rs1;   // rs1 is a real source
        logic use_rs2;   // rs2 is a real source
        logic alu_sub;
        logic use_imm;   // second alu operand is the immediate
    } ctrl_t;

endpackage

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    // major opcodes of the supported rv32i subset
    localparam logic [6:0] OP_REG    = 7'b0110011; // add, sub
    localparam logic [6:0] OP_IMM    = 7'b0010011; // addi
    localparam logic [6:0] OP_LOAD   = 7'b0000011; // lw
    localparam logic [6:0] OP_STORE  = 7'b0100011; // sw
    localparam logic [6:0] OP_BRANCH = 7'b1100011; // beq

    localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_WORD = 3'b010; // lw, sw
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [6:0] F7_ADD  = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // store immediate is split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;  // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;  // imm[4:0], sits where rd would be
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;  // odd one out, bit 7 of the word
        logic [6:0] opcode;
    } b_fmt_t;

    // one instruction word, four views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_u;

endpackage

// ==== hw/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath and address width
`define XLEN 32
// register index width, 32 architectural registers
`define REG_AW 5
// data memory depth in 32-bit words
`define DMEM_WORDS 256
`define RESET_PC 32'h0000_0000 // first fetch address out of reset

`endif
